// ==== all.f ====
+incdir+source
source/rename_pkg.sv
source/map_write_if.sv
source/dest_alloc.sv
source/src_bypass.sv
source/map_write_arbiter.sv
source/map_ram.sv
source/rename_map_top.sv
tb/rename_map_chk.sv
tb/rename_map_tb.sv

// ==== tb/rename_map_tb.sv ====
/*
  rename map table testbench
  random and directed bundles against a reference map model,
  stalls, recovery and repair
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_map_tb;

  localparam int TIMEOUT_CYCLES = 20;

  typedef logic [`RN_DISPATCH_WIDTH-1:0] lane_mask_t;

  logic                                          clk;
  logic                                          rst_n_i;
  logic                                          in_valid_i;
  logic                                          in_ready_o;
  logic                                          out_valid_o;
  logic                                          out_ready_i;
  logic                                          recover_i;
  logic                                          repair_i;
  rename_pkg::log_id_t  [`RN_REPAIR_PACKETS-1:0] repair_addr_i;
  rename_pkg::phys_id_t [`RN_REPAIR_PACKETS-1:0] repair_data_i;
  rename_pkg::lane_log_t                         log_dest_i;
  rename_pkg::lane_log_t                         log_src1_i;
  rename_pkg::lane_log_t                         log_src2_i;
  rename_pkg::lane_id_t                          free_phys_i;
  rename_pkg::lane_phys_t                        phy_dest_o;
  rename_pkg::lane_phys_t                        phy_src1_o;
  rename_pkg::lane_phys_t                        phy_src2_o;

  // reference copy of the map table
  rename_pkg::phys_id_t model_map [`RN_LOG_REGS];
  integer seed = 32'h8fe4c456;
  int     errors = 0;
  int     timeouts = 0;
  int     checks = 0;
  string  test_name = "reset";

  rename_map_top uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // nearest older producer first, else the table
  function automatic rename_pkg::phys_reg_t expect_src(
    input rename_pkg::log_reg_t   src,
    input int                     lane,
    input rename_pkg::lane_log_t  dst,
    input rename_pkg::lane_phys_t e_dst
  );
    if (src.valid)
    begin
      for (int j = lane - 1; j >= 0; j--)
      begin
        if (dst[j].valid && dst[j].reg_id == src.reg_id)
        begin
          return {1'b1, e_dst[j].reg_id};
        end
      end
    end
    return {src.valid, model_map[src.reg_id]};
  endfunction

  // expected renaming of one bundle
  function automatic void ref_rename(
    input  rename_pkg::lane_log_t  dst,
    input  rename_pkg::lane_log_t  s1,
    input  rename_pkg::lane_log_t  s2,
    input  rename_pkg::lane_id_t   fr,
    output rename_pkg::lane_phys_t e_dst,
    output rename_pkg::lane_phys_t e_s1,
    output rename_pkg::lane_phys_t e_s2
  );
    int nxt;
    nxt = 0;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      e_dst[i] = '0;
      if (dst[i].valid)
      begin
        e_dst[i] = {1'b1, fr[nxt]};
        nxt++;
      end
    end
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      e_s1[i] = expect_src(s1[i], i, dst, e_dst);
      e_s2[i] = expect_src(s2[i], i, dst, e_dst);
    end
  endfunction

  function automatic rename_pkg::lane_log_t rand_lanes(
    input lane_mask_t mask
  );
    rename_pkg::lane_log_t l;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      l[i].valid  = mask[i];
      l[i].reg_id = rename_pkg::log_id_t'($random(seed));
    end
    return l;
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("ERR %s %s expected %h actual %h", test_name, sig, exp, act);
    end
  endtask

  // compare 1 ns before each edge, then follow the commit in the model
  initial
  begin
    rename_pkg::lane_phys_t e_dst;
    rename_pkg::lane_phys_t e_s1;
    rename_pkg::lane_phys_t e_s2;
    logic                   e_ready;
    logic                   e_valid;
    forever
    begin
      @(posedge clk);
      #9;
      if (rst_n_i)
      begin
        ref_rename(log_dest_i, log_src1_i, log_src2_i, free_phys_i, e_dst, e_s1, e_s2);
        e_ready = out_ready_i & ~repair_i & ~recover_i;
        e_valid = in_valid_i & ~repair_i & ~recover_i;
        check_value("in_ready_o", e_ready, in_ready_o);
        check_value("out_valid_o", e_valid, out_valid_o);
        check_value("phy_dest_o", e_dst, phy_dest_o);
        check_value("phy_src1_o", e_s1, phy_src1_o);
        check_value("phy_src2_o", e_s2, phy_src2_o);
        if (repair_i)
        begin
          for (int k = 0; k < `RN_REPAIR_PACKETS; k++)
          begin
            model_map[repair_addr_i[k]] = repair_data_i[k];
          end
        end
        else if (in_valid_i && e_ready)
        begin
          // ascending order, so the youngest lane lands last
          for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
          begin
            if (log_dest_i[i].valid)
            begin
              model_map[log_dest_i[i].reg_id] = e_dst[i].reg_id;
            end
          end
        end
      end
    end
  end

  task automatic set_bundle(
    input rename_pkg::lane_log_t dst,
    input rename_pkg::lane_log_t s1,
    input rename_pkg::lane_log_t s2
  );
    log_dest_i = dst;
    log_src1_i = s1;
    log_src2_i = s2;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      free_phys_i[i] = rename_pkg::phys_id_t'($random(seed));
    end
    in_valid_i = 1'b1;
  endtask

  // hold the bundle until it is accepted
  task automatic push_bundle(
    input rename_pkg::lane_log_t dst,
    input rename_pkg::lane_log_t s1,
    input rename_pkg::lane_log_t s2
  );
    int waited;
    set_bundle(dst, s1, s2);
    waited = 0;
    #4;
    while (!in_ready_o && waited < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      #5;
      waited++;
    end
    if (!in_ready_o)
    begin
      timeouts++;
      $display("timeout, bundle in %s was never accepted", test_name);
    end
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
  endtask

  initial
  begin
    rename_pkg::lane_log_t dst;
    rename_pkg::lane_log_t s1;
    rename_pkg::lane_log_t s2;
    for (int r = 0; r < `RN_LOG_REGS; r++)
    begin
      model_map[r] = rename_pkg::phys_id_t'(r);
    end
    rst_n_i       = 1'b0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    recover_i     = 1'b0;
    repair_i      = 1'b0;
    repair_addr_i = '0;
    repair_data_i = '0;
    log_dest_i    = '0;
    log_src1_i    = '0;
    log_src2_i    = '0;
    free_phys_i   = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // table untouched since reset
    test_name = "identity";
    repeat (4) push_bundle('0, rand_lanes('1), rand_lanes('1));

    test_name = "alloc";
    repeat (8)
    begin
      dst = rand_lanes(lane_mask_t'($random(seed)));
      s1  = rand_lanes(lane_mask_t'($random(seed)));
      s2  = rand_lanes(lane_mask_t'($random(seed)));
      push_bundle(dst, s1, s2);
    end

    test_name = "bypass";
    dst = '0;
    s1  = '0;
    s2  = '0;
    dst[0] = {1'b1, 5'd5};
    dst[1] = {1'b1, 5'd5};
    dst[2] = {1'b1, 5'd7};
    // r7 only written by a younger lane
    s1[1] = {1'b1, 5'd7};
    s2[1] = {1'b1, 5'd5};
    s1[2] = {1'b1, 5'd5};
    s2[3] = {1'b1, 5'd5};
    push_bundle(dst, s1, s2);

    test_name = "youngest";
    dst = '0;
    dst[0] = {1'b1, 5'd9};
    dst[2] = {1'b1, 5'd9};
    dst[3] = {1'b1, 5'd9};
    push_bundle(dst, '0, '0);
    s1 = '0;
    s1[0] = {1'b1, 5'd9};
    s1[3] = {1'b1, 5'd9};
    push_bundle('0, s1, s1);

    // stalled bundle must not reach the table
    test_name = "backpressure";
    dst = rand_lanes('1);
    out_ready_i = 1'b0;
    set_bundle(dst, rand_lanes('1), rand_lanes('1));
    repeat (2) @(posedge clk);
    #1;
    test_name = "recover";
    out_ready_i = 1'b1;
    recover_i   = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    recover_i  = 1'b0;
    in_valid_i = 1'b0;
    test_name  = "after_stall";
    push_bundle('0, dst, dst);

    // restore r10..r15 while a bundle waits
    test_name = "repair";
    set_bundle(rand_lanes('1), rand_lanes('1), rand_lanes('1));
    repair_i = 1'b1;
    for (int c = 0; c < 3; c++)
    begin
      for (int k = 0; k < `RN_REPAIR_PACKETS; k++)
      begin
        repair_addr_i[k] = rename_pkg::log_id_t'(10 + c * `RN_REPAIR_PACKETS + k);
        repair_data_i[k] = rename_pkg::phys_id_t'($random(seed));
      end
      @(posedge clk);
      #1;
    end
    repair_i   = 1'b0;
    in_valid_i = 1'b0;
    test_name  = "after_repair";
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      s1[i] = {1'b1, rename_pkg::log_id_t'(10 + i)};
      s2[i] = {1'b1, rename_pkg::log_id_t'(12 + i)};
    end
    push_bundle('0, s1, s2);

    test_name = "drain";
    repeat (2) @(posedge clk);
    #1;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, uut.u_chk.fail_count);
    if (errors == 0 && timeouts == 0 && uut.u_chk.fail_count == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb/rename_map_chk.sv ====
/*
  rename map table checker
  handshake blocking, output valid rule and known outputs after reset
*/
`timescale 1ns/1ps

module rename_map_chk (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   in_valid_i,
  input logic                   in_ready_o,
  input logic                   out_valid_o,
  input logic                   recover_i,
  input logic                   repair_i,
  input rename_pkg::lane_phys_t phy_dest_o,
  input rename_pkg::lane_phys_t phy_src1_o,
  input rename_pkg::lane_phys_t phy_src2_o
);

  // assertion failures seen so far
  int unsigned fail_count = 0;

  // no acceptance while the table is restored or flushed
  blocked_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
    (repair_i || recover_i) |-> !in_ready_o)
    else
    begin
      fail_count++;
      $error("in_ready_o high during repair or recovery");
    end

  // downstream valid only with an upstream bundle
  valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_o |-> in_valid_i)
    else
    begin
      fail_count++;
      $error("out_valid_o high without in_valid_i");
    end

  known_outputs: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown({in_ready_o, out_valid_o, phy_dest_o, phy_src1_o, phy_src2_o}))
    else
    begin
      fail_count++;
      $error("rename outputs unknown after reset");
    end

endmodule

bind rename_map_top rename_map_chk u_chk (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .recover_i   (recover_i),
  .repair_i    (repair_i),
  .phy_dest_o  (phy_dest_o),
  .phy_src1_o  (phy_src1_o),
  .phy_src2_o  (phy_src2_o)
);

// ==== source/rename_map_top.sv ====
/*
  register rename map table
  renames a bundle of up to four instructions against the map table,
  commits new mappings on acceptance and restores them on repair
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module rename_map_top (
  input  logic                                           clk,
  input  logic                                           rst_n_i,

  // handshake and pipeline control
  input  logic                                           in_valid_i,
  output logic                                           in_ready_o,
  output logic                                           out_valid_o,
  input  logic                                           out_ready_i,
  input  logic                                           recover_i,

  // architectural map packets
  input  logic                                           repair_i,
  input  rename_pkg::log_id_t  [`RN_REPAIR_PACKETS-1:0]  repair_addr_i,
  input  rename_pkg::phys_id_t [`RN_REPAIR_PACKETS-1:0]  repair_data_i,

  // decoded bundle and free list head
  input  rename_pkg::lane_log_t                          log_dest_i,
  input  rename_pkg::lane_log_t                          log_src1_i,
  input  rename_pkg::lane_log_t                          log_src2_i,
  input  rename_pkg::lane_id_t                           free_phys_i,

  // renamed bundle
  output rename_pkg::lane_phys_t                         phy_dest_o,
  output rename_pkg::lane_phys_t                         phy_src1_o,
  output rename_pkg::lane_phys_t                         phy_src2_o
);

  // table read ports, two per lane
  rename_pkg::log_id_t  [2*`RN_DISPATCH_WIDTH-1:0] rd_addr;
  rename_pkg::phys_id_t [2*`RN_DISPATCH_WIDTH-1:0] rd_data;

  // bundle writes toward the arbiter
  map_write_if #(.LANES(`RN_DISPATCH_WIDTH)) ren_wr ();
  // arbitrated writes toward the table
  map_write_if #(.LANES(`RN_WR_LANES))       ram_wr ();

  dest_alloc u_dest_alloc (
    .log_dest_i  (log_dest_i),
    .free_phys_i (free_phys_i),
    .phy_dest_o  (phy_dest_o),
    .ren_wr      (ren_wr.requester)
  );

  // bypass needs the freshly allocated dests
  src_bypass u_src_bypass (
    .log_src1_i  (log_src1_i),
    .log_src2_i  (log_src2_i),
    .log_dest_i  (log_dest_i),
    .phy_dest_i  (phy_dest_o),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .phy_src1_o  (phy_src1_o),
    .phy_src2_o  (phy_src2_o)
  );

  map_write_arbiter u_arbiter (
    .in_valid_i    (in_valid_i),
    .out_ready_i   (out_ready_i),
    .recover_i     (recover_i),
    .repair_i      (repair_i),
    .repair_addr_i (repair_addr_i),
    .repair_data_i (repair_data_i),
    .in_ready_o    (in_ready_o),
    .out_valid_o   (out_valid_o),
    .ren_wr        (ren_wr.arbiter),
    .ram_wr        (ram_wr.requester)
  );

  map_ram u_map_ram (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .ram_wr    (ram_wr.ram)
  );

endmodule

// ==== source/map_ram.sv ====
/*
  rename map table storage
  one physical id per logical register, identity after reset,
  combinational read ports and write lanes applied at the clock edge
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module map_ram (
  input  logic                                           clk,
  input  logic                                           rst_n_i,
  input  rename_pkg::log_id_t  [2*`RN_DISPATCH_WIDTH-1:0] rd_addr_i,
  output rename_pkg::phys_id_t [2*`RN_DISPATCH_WIDTH-1:0] rd_data_o,
  map_write_if.ram                                       ram_wr
);

  rename_pkg::phys_id_t map_q [`RN_LOG_REGS];

  // logical n -> physical n out of reset
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int r = 0; r < `RN_LOG_REGS; r++)
      begin
        map_q[r] <= rename_pkg::phys_id_t'(r);
      end
    end
    else
    begin
      // later lane overrides on the same address
      for (int k = 0; k < `RN_WR_LANES; k++)
      begin
        if (ram_wr.we[k])
        begin
          map_q[ram_wr.addr[k]] <= ram_wr.data[k];
        end
      end
    end
  end

  // read before write, new values show next cycle
  always_comb
  begin
    for (int p = 0; p < 2*`RN_DISPATCH_WIDTH; p++)
    begin
      rd_data_o[p] = map_q[rd_addr_i[p]];
    end
  end

endmodule

// ==== source/map_write_arbiter.sv ====
/*
  map table write arbiter
  valid/ready handshake of the rename stage, and selection between
  bundle writes and architectural repair packets on the shared lanes
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module map_write_arbiter (
  input  logic                                             in_valid_i,
  input  logic                                             out_ready_i,
  input  logic                                             recover_i,
  input  logic                                             repair_i,
  input  rename_pkg::log_id_t  [`RN_REPAIR_PACKETS-1:0]    repair_addr_i,
  input  rename_pkg::phys_id_t [`RN_REPAIR_PACKETS-1:0]    repair_data_i,
  output logic                                             in_ready_o,
  output logic                                             out_valid_o,
  map_write_if.arbiter                                     ren_wr,
  map_write_if.requester                                   ram_wr
);

  // no bundle moves during repair or pipeline flush
  assign in_ready_o  = out_ready_i & ~repair_i & ~recover_i;
  assign out_valid_o = in_valid_i & ~repair_i & ~recover_i;

  // bundle committed on acceptance
  assign ren_wr.grant = in_valid_i & in_ready_o;

  always_comb
  begin
    ram_wr.we   = '0;
    ram_wr.addr = '0;
    ram_wr.data = '0;
    if (repair_i)
    begin
      // repair owns the lanes, recover does not stop the AMT copy
      for (int k = 0; k < `RN_REPAIR_PACKETS; k++)
      begin
        ram_wr.we[k]   = 1'b1;
        ram_wr.addr[k] = repair_addr_i[k];
        ram_wr.data[k] = repair_data_i[k];
      end
    end
    else if (ren_wr.grant)
    begin
      // already deduplicated upstream, so no address clash
      for (int k = 0; k < `RN_DISPATCH_WIDTH; k++)
      begin
        ram_wr.we[k]   = ren_wr.we[k];
        ram_wr.addr[k] = ren_wr.addr[k];
        ram_wr.data[k] = ren_wr.data[k];
      end
    end
  end

endmodule

// ==== source/src_bypass.sv ====
/*
  source renaming
  reads the map table per source and overrides it with the youngest
  older in-bundle producer of the same logical register
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module src_bypass (
  input  rename_pkg::lane_log_t                                 log_src1_i,
  input  rename_pkg::lane_log_t                                 log_src2_i,
  input  rename_pkg::lane_log_t                                 log_dest_i,
  input  rename_pkg::lane_phys_t                                phy_dest_i,
  output rename_pkg::log_id_t  [2*`RN_DISPATCH_WIDTH-1:0]       rd_addr_o,
  input  rename_pkg::phys_id_t [2*`RN_DISPATCH_WIDTH-1:0]       rd_data_i,
  output rename_pkg::lane_phys_t                                phy_src1_o,
  output rename_pkg::lane_phys_t                                phy_src2_o
);

  // one source against all older lanes of the bundle
  function automatic rename_pkg::phys_reg_t pick_src(
    input rename_pkg::log_reg_t   src,
    input int                     lane,
    input rename_pkg::phys_id_t   table_val,
    input rename_pkg::lane_log_t  dests,
    input rename_pkg::lane_phys_t phys
  );
    rename_pkg::phys_reg_t res;
    res.valid  = src.valid;
    res.reg_id = table_val;
    // ascending scan, so the youngest older match lands last
    for (int j = 0; j < `RN_DISPATCH_WIDTH; j++)
    begin
      if (j < lane && src.valid && dests[j].valid && dests[j].reg_id == src.reg_id)
      begin
        res.reg_id = phys[j].reg_id;
      end
    end
    return res;
  endfunction

  // read ports interleaved, src1 on even, src2 on odd
  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      rd_addr_o[2*i]   = log_src1_i[i].reg_id;
      rd_addr_o[2*i+1] = log_src2_i[i].reg_id;
    end
  end

  always_comb
  begin
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      phy_src1_o[i] = pick_src(log_src1_i[i], i, rd_data_i[2*i], log_dest_i, phy_dest_i);
      phy_src2_o[i] = pick_src(log_src2_i[i], i, rd_data_i[2*i+1], log_dest_i, phy_dest_i);
    end
  end

endmodule

// ==== source/dest_alloc.sv ====
/*
  destination allocation
  hands out free physical registers to valid destinations in packed
  order and raises a table write only for the youngest writer of each id
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

module dest_alloc (
  input  rename_pkg::lane_log_t  log_dest_i,
  input  rename_pkg::lane_id_t   free_phys_i,
  output rename_pkg::lane_phys_t phy_dest_o,
  map_write_if.requester         ren_wr
);

  // packed allocation, free list entry = number of valid dests below this lane
  always_comb
  begin
    int unsigned used;
    used = 0;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      phy_dest_o[i].valid  = log_dest_i[i].valid;
      phy_dest_o[i].reg_id = '0;
      if (log_dest_i[i].valid)
      begin
        phy_dest_o[i].reg_id = free_phys_i[used];
        used++;
      end
    end
  end

  // youngest write wins
  always_comb
  begin
    logic shadowed;
    for (int i = 0; i < `RN_DISPATCH_WIDTH; i++)
    begin
      shadowed = 1'b0;
      // any younger lane writing the same id hides this one
      for (int j = 0; j < `RN_DISPATCH_WIDTH; j++)
      begin
        if (j > i && log_dest_i[j].valid && log_dest_i[j].reg_id == log_dest_i[i].reg_id)
        begin
          shadowed = 1'b1;
        end
      end
      ren_wr.we[i]   = log_dest_i[i].valid & ~shadowed;
      ren_wr.addr[i] = log_dest_i[i].reg_id;
      ren_wr.data[i] = phy_dest_o[i].reg_id;
    end
  end

endmodule

// ==== source/map_write_if.sv ====
/*
  map table write lanes
  per-lane enable, logical address and physical data plus one grant
*/
`timescale 1ns/1ps
`include "rename_consts.svh"

interface map_write_if #(
  parameter int LANES = `RN_DISPATCH_WIDTH
);

  // per-lane write request
  logic                             [LANES-1:0] we;
  rename_pkg::log_id_t  [LANES-1:0] addr;
  rename_pkg::phys_id_t [LANES-1:0] data;

  // writes will be committed this cycle
  logic                             grant;

  modport requester (output we, addr, data, input grant);
  modport arbiter   (input we, addr, data, output grant);
  modport ram       (input we, addr, data);

endinterface

// ==== source/rename_pkg.sv ====
/*
  rename stage types
  register tags with valid bits and the per-lane bundle arrays
*/
`include "rename_consts.svh"

package rename_pkg;

  // bare ids
  typedef logic [`RN_LOG_BITS-1:0]  log_id_t;
  typedef logic [`RN_PHYS_BITS-1:0] phys_id_t;

  // logical tag as decoded
  typedef struct packed
  {
    logic    valid;
    log_id_t reg_id;
  } log_reg_t;

  // renamed tag
  typedef struct packed
  {
    logic     valid;
    phys_id_t reg_id;
  } phys_reg_t;

  // one entry per dispatch lane, lane 0 is the oldest
  typedef log_reg_t  [`RN_DISPATCH_WIDTH-1:0] lane_log_t;
  typedef phys_reg_t [`RN_DISPATCH_WIDTH-1:0] lane_phys_t;
  typedef phys_id_t  [`RN_DISPATCH_WIDTH-1:0] lane_id_t;

endpackage

// ==== source/rename_consts.svh ====
/*
  rename stage sizing
  dispatch width, register counts and tag widths
*/
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// instructions per rename bundle
`define RN_DISPATCH_WIDTH 4

// architectural register file
`define RN_LOG_REGS 32
`define RN_LOG_BITS 5

// physical register tag width
`define RN_PHYS_BITS 6

// architectural map entries restored per repair cycle
`define RN_REPAIR_PACKETS 2

// map table write lanes, the larger of bundle width and packet count
`define RN_WR_LANES ((`RN_DISPATCH_WIDTH > `RN_REPAIR_PACKETS) ? \
                     `RN_DISPATCH_WIDTH : `RN_REPAIR_PACKETS)

`endif
